//--- source/snes_mem_cfg.svh
// memory front end configuration: address widths and cartridge mapping codes
`ifndef SNES_MEM_CFG_SVH
`define SNES_MEM_CFG_SVH

// sdram byte address, 8 MB
`define SDRAM_AW 23

// console side address widths
`define WRAM_AW 17
`define BSRAM_AW 20

// vram address bits seen by the read filter
`define VRAM_AW 15

// WRAM lives in the top 128 KB of sdram
`define WRAM_BANK_PREFIX 6'b111111

// upper rom_type nibble of carts that read bsram without the read strobe
`define ROM_TYPE_SRAM_MAP 4'hC

`endif

//--- source/snes_mem_pkg.sv
// shared data, address and state types of the memory request front end
`default_nettype none

`include "snes_mem_cfg.svh"

package snes_mem_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [15:0] word_t;
    typedef logic [1:0]  byte_en_t;    // {upper, lower}

    typedef logic [`SDRAM_AW-1:0] sdram_addr_t;
    typedef logic [23:0]          rom_addr_t;
    typedef logic [`WRAM_AW-1:0]  wram_addr_t;
    typedef logic [`BSRAM_AW-1:0] bsram_addr_t;
    typedef logic [15:0]          vram_addr_t;
    typedef logic [15:0]          aram_addr_t;

    typedef enum logic [1:0] {
        LOAD_IDLE,
        LOAD_ACTIVE,
        LOAD_DONE
    } load_state_t;

    // source served by the arbiter in the last cycle
    typedef enum logic [2:0] {
        REQ_NONE,
        REQ_LOAD,
        REQ_LOAD_HOLD,
        REQ_WRAM,
        REQ_ROM
    } req_kind_t;

endpackage

`default_nettype wire

//--- source/load_ctrl.sv
// ROM load sequencer: loader byte address, loaded state and console run enable
`timescale 1ns/1ns
`default_nettype none

module load_ctrl (
    input  logic                   mclk,
    input  logic                   resetn,
    input  logic                   loading,
    input  logic                   loader_do_valid,
    input  logic                   header_finished,
    input  logic                   sdram_busy,
    input  logic                   frame_pause,
    output snes_mem_pkg::rom_addr_t loader_addr,
    output logic                   enable
);
    import snes_mem_pkg::*;

    logic        loading_r;
    load_state_t state;
    logic        load_rise;
    logic        load_fall;

    assign load_rise = loading & ~loading_r;
    assign load_fall = ~loading & loading_r;

    always_ff @(posedge mclk) begin
        if (!resetn) begin
            loading_r   <= 1'b0;
            state       <= LOAD_IDLE;
            loader_addr <= '0;
        end else begin
            loading_r <= loading;
            if (load_rise) begin
                loader_addr <= '0;           // new image starts at address 0
                state       <= LOAD_ACTIVE;
            end else begin
                if (loader_do_valid && header_finished)
                    loader_addr <= loader_addr + 24'd1;
                if (load_fall)
                    state <= LOAD_DONE;
            end
        end
    end

    // console only runs after a complete load, sdram ready, no frame pause
    always_ff @(posedge mclk) begin
        if (!resetn)
            enable <= 1'b0;
        else
            enable <= ~sdram_busy & ~frame_pause & (state == LOAD_DONE);
    end

endmodule

`default_nettype wire

//--- source/mem_req_arbiter.sv
// SDRAM request arbiter: loader writes, WRAM and ROM cycles, plus BSRAM strobes
`timescale 1ns/1ns
`default_nettype none

`include "snes_mem_cfg.svh"

module mem_req_arbiter (
    input  logic                      mclk,
    input  logic                      resetn,
    input  logic                      enable,
    input  logic                      sysclkf_ce,
    input  logic                      sysclkr_ce,
    input  logic                      loading,
    input  logic                      loader_do_valid,
    input  logic                      header_finished,
    input  snes_mem_pkg::byte_t       loader_do,
    input  snes_mem_pkg::rom_addr_t   loader_addr,
    input  snes_mem_pkg::rom_addr_t   rom_addr,
    input  logic                      rom_ce_n,
    input  snes_mem_pkg::wram_addr_t  wram_addr,
    input  logic                      wram_ce_n,
    input  logic                      wram_rd_n,
    input  logic                      wram_we_n,
    input  snes_mem_pkg::byte_t       wram_d,
    input  snes_mem_pkg::bsram_addr_t bsram_addr_in,
    input  logic                      bsram_ce_n,
    input  logic                      bsram_rd_n,
    input  logic                      bsram_we_n,
    input  snes_mem_pkg::byte_t       bsram_d,
    input  snes_mem_pkg::byte_t       rom_type,
    output snes_mem_pkg::sdram_addr_t cpu_addr,
    output snes_mem_pkg::word_t       cpu_din,
    output snes_mem_pkg::byte_en_t    cpu_ds,
    output logic                      cpu_port,
    output logic                      cpu_rd,
    output logic                      cpu_wr,
    output snes_mem_pkg::bsram_addr_t bsram_addr,
    output snes_mem_pkg::byte_t       bsram_din,
    output logic                      bsram_rd,
    output logic                      bsram_wr
);
    import snes_mem_pkg::*;

    logic        f2, r2;             // phase enables aligned to mclk
    req_kind_t   last_kind;
    req_kind_t   kind_d;
    logic        rd_d, wr_d, port_d;
    sdram_addr_t addr_d;
    word_t       din_d;
    byte_en_t    ds_d;
    logic        load_byte, wram_rd, wram_wr, bsram_rd_t;

    assign load_byte = loading & loader_do_valid & header_finished;
    assign wram_rd   = ~wram_ce_n & ~wram_rd_n;
    assign wram_wr   = ~wram_ce_n & ~wram_we_n;
    // sram mapped carts read bsram without a read strobe
    assign bsram_rd_t = ~bsram_ce_n & f2 &
                        (~bsram_rd_n | (rom_type[7:4] == `ROM_TYPE_SRAM_MAP));

    always_comb begin
        kind_d = REQ_NONE;
        rd_d   = 1'b0;
        wr_d   = 1'b0;
        addr_d = cpu_addr;           // payload holds unless a source is taken
        din_d  = cpu_din;
        ds_d   = cpu_ds;
        port_d = cpu_port;
        if (last_kind == REQ_LOAD) begin
            kind_d = REQ_LOAD_HOLD;  // second cycle of the loader write
            wr_d   = 1'b1;
        end else if (load_byte) begin
            kind_d = REQ_LOAD;
            wr_d   = 1'b1;
            addr_d = loader_addr[`SDRAM_AW-1:0];
            din_d  = {loader_do, loader_do};
            ds_d   = {loader_addr[0], ~loader_addr[0]};
            port_d = 1'b0;
        end else if (wram_rd | wram_wr) begin
            kind_d = REQ_WRAM;
            addr_d = {`WRAM_BANK_PREFIX, wram_addr};
            din_d  = {wram_d, wram_d};
            ds_d   = {wram_addr[0], ~wram_addr[0]};
            port_d = 1'b1;
            rd_d   = wram_rd & f2;
            wr_d   = wram_wr & r2;
        end else if (~rom_ce_n && ~bsram_rd_t && f2) begin
            kind_d = REQ_ROM;
            rd_d   = 1'b1;
            addr_d = rom_addr[`SDRAM_AW-1:0];
            ds_d   = 2'b11;
            port_d = 1'b0;
        end
    end

    always_ff @(posedge mclk) begin
        if (!resetn) begin
            f2        <= 1'b0;
            r2        <= 1'b0;
            last_kind <= REQ_NONE;
            cpu_rd    <= 1'b0;
            cpu_wr    <= 1'b0;
            bsram_rd  <= 1'b0;
            bsram_wr  <= 1'b0;
        end else begin
            f2        <= sysclkf_ce & enable;
            r2        <= sysclkr_ce & enable;
            last_kind <= kind_d;
            cpu_rd    <= rd_d;
            cpu_wr    <= wr_d;
            bsram_rd  <= bsram_rd_t;
            bsram_wr  <= ~bsram_ce_n & ~bsram_we_n & r2;
        end
    end

    always_ff @(posedge mclk) begin
        cpu_addr   <= addr_d;
        cpu_din    <= din_d;
        cpu_ds     <= ds_d;
        cpu_port   <= port_d;
        bsram_addr <= bsram_addr_in;  // sampled every cycle
        bsram_din  <= bsram_d;
    end

endmodule

`default_nettype wire

//--- source/read_data_steer.sv
// read data steering from SDRAM port words to ROM, WRAM and ARAM buses
`timescale 1ns/1ns
`default_nettype none

module read_data_steer (
    input  logic                     mclk,
    input  logic                     resetn,
    input  snes_mem_pkg::word_t      cpu_port0,
    input  snes_mem_pkg::word_t      cpu_port1,
    input  snes_mem_pkg::rom_addr_t  rom_addr,
    input  logic                     rom_word,
    input  snes_mem_pkg::wram_addr_t wram_addr,
    input  snes_mem_pkg::aram_addr_t aram_addr,
    input  logic                     aram_ce_n,
    input  logic                     aram_oe_n,
    input  snes_mem_pkg::word_t      aram_dout,
    output snes_mem_pkg::word_t      rom_q,
    output snes_mem_pkg::byte_t      wram_q,
    output snes_mem_pkg::byte_t      aram_q
);
    import snes_mem_pkg::*;

    word_t rom_swapped;
    logic  aram_lsb;                 // byte lane of the last aram read

    assign rom_swapped = {cpu_port0[7:0], cpu_port0[15:8]};
    assign rom_q  = (rom_word | ~rom_addr[0]) ? cpu_port0 : rom_swapped;
    assign wram_q = wram_addr[0] ? cpu_port1[15:8] : cpu_port1[7:0];
    assign aram_q = aram_lsb ? aram_dout[15:8] : aram_dout[7:0];

    always_ff @(posedge mclk) begin
        if (!resetn)
            aram_lsb <= 1'b0;
        else if (~aram_ce_n & ~aram_oe_n)
            aram_lsb <= aram_addr[0];  // data arrives after the address
    end

endmodule

`default_nettype wire

//--- source/vram_read_filter.sv
// VRAM read filter: drops repeated reads, serializes conflicting port 2 reads
`timescale 1ns/1ns
`default_nettype none

`include "snes_mem_cfg.svh"

module vram_read_filter (
    input  logic                     mclk,
    input  logic                     resetn,
    input  snes_mem_pkg::vram_addr_t vram1_addr,
    input  snes_mem_pkg::vram_addr_t vram2_addr,
    input  logic                     vram_oe_n,
    output logic                     vram1_rd,
    output logic                     vram2_rd
);
    import snes_mem_pkg::*;

    logic               vram_oe_n_old;
    logic [`VRAM_AW-1:0] vram1_addr_old;
    logic [`VRAM_AW-1:0] vram2_addr_old;
    logic               vram1_new, vram2_new;
    logic               vram2_delay, vram2_delay_r;

    // new read: oe just asserted or address moved
    assign vram1_new = ~vram_oe_n &
                       (vram_oe_n_old | (vram1_addr_old != vram1_addr[`VRAM_AW-1:0]));
    assign vram2_new = ~vram_oe_n &
                       (vram_oe_n_old | (vram2_addr_old != vram2_addr[`VRAM_AW-1:0]));

    // both ports want different words, port 2 waits a cycle
    assign vram2_delay = vram1_new & vram2_new & (vram1_addr != vram2_addr);

    assign vram1_rd = vram1_new;
    assign vram2_rd = (vram2_new & ~vram2_delay) | vram2_delay_r;

    always_ff @(posedge mclk) begin
        if (!resetn) begin
            vram_oe_n_old <= 1'b1;
            vram2_delay_r <= 1'b0;
        end else begin
            vram_oe_n_old <= vram_oe_n;
            vram2_delay_r <= vram2_delay;
        end
    end

    always_ff @(posedge mclk) begin
        vram1_addr_old <= vram1_addr[`VRAM_AW-1:0];
        vram2_addr_old <= vram2_addr[`VRAM_AW-1:0];
    end

endmodule

`default_nettype wire

//--- source/snes_mem_top.sv
// SNES memory request front end between console buses and the SDRAM controller
`timescale 1ns/1ns
`default_nettype none

module snes_mem_top (
    input  logic                      mclk,
    input  logic                      resetn,
    input  logic                      frame_pause,
    input  logic                      sdram_busy,
    input  logic                      loading,
    input  snes_mem_pkg::byte_t       loader_do,
    input  logic                      loader_do_valid,
    input  logic                      header_finished,
    input  snes_mem_pkg::byte_t       rom_type,
    input  logic                      sysclkf_ce,
    input  logic                      sysclkr_ce,
    input  snes_mem_pkg::rom_addr_t   rom_addr,
    input  logic                      rom_ce_n,
    input  logic                      rom_word,
    input  snes_mem_pkg::wram_addr_t  wram_addr,
    input  logic                      wram_ce_n,
    input  logic                      wram_rd_n,
    input  logic                      wram_we_n,
    input  snes_mem_pkg::byte_t       wram_d,
    input  snes_mem_pkg::bsram_addr_t bsram_addr_cpu,
    input  logic                      bsram_ce_n,
    input  logic                      bsram_rd_n,
    input  logic                      bsram_we_n,
    input  snes_mem_pkg::byte_t       bsram_d,
    input  snes_mem_pkg::aram_addr_t  aram_addr,
    input  logic                      aram_ce_n,
    input  logic                      aram_oe_n,
    input  snes_mem_pkg::word_t       aram_dout,
    input  snes_mem_pkg::vram_addr_t  vram1_addr,
    input  snes_mem_pkg::vram_addr_t  vram2_addr,
    input  logic                      vram_oe_n,
    input  snes_mem_pkg::word_t       cpu_port0,
    input  snes_mem_pkg::word_t       cpu_port1,
    output logic                      enable,
    output snes_mem_pkg::sdram_addr_t cpu_addr,
    output snes_mem_pkg::word_t       cpu_din,
    output snes_mem_pkg::byte_en_t    cpu_ds,
    output logic                      cpu_port,
    output logic                      cpu_rd,
    output logic                      cpu_wr,
    output snes_mem_pkg::bsram_addr_t bsram_addr,
    output snes_mem_pkg::byte_t       bsram_din,
    output logic                      bsram_rd,
    output logic                      bsram_wr,
    output snes_mem_pkg::word_t       rom_q,
    output snes_mem_pkg::byte_t       wram_q,
    output snes_mem_pkg::byte_t       aram_q,
    output logic                      vram1_rd,
    output logic                      vram2_rd
);
    import snes_mem_pkg::*;

    rom_addr_t loader_addr;          // loader byte counter to the arbiter

    load_ctrl load_ctrl0 (
        .mclk(mclk), .resetn(resetn),
        .loading(loading), .loader_do_valid(loader_do_valid),
        .header_finished(header_finished),
        .sdram_busy(sdram_busy), .frame_pause(frame_pause),
        .loader_addr(loader_addr), .enable(enable)
    );

    mem_req_arbiter arb0 (
        .mclk(mclk), .resetn(resetn), .enable(enable),
        .sysclkf_ce(sysclkf_ce), .sysclkr_ce(sysclkr_ce),
        .loading(loading), .loader_do_valid(loader_do_valid),
        .header_finished(header_finished), .loader_do(loader_do),
        .loader_addr(loader_addr), .rom_addr(rom_addr), .rom_ce_n(rom_ce_n),
        .wram_addr(wram_addr), .wram_ce_n(wram_ce_n),
        .wram_rd_n(wram_rd_n), .wram_we_n(wram_we_n), .wram_d(wram_d),
        .bsram_addr_in(bsram_addr_cpu), .bsram_ce_n(bsram_ce_n),
        .bsram_rd_n(bsram_rd_n), .bsram_we_n(bsram_we_n), .bsram_d(bsram_d),
        .rom_type(rom_type),
        .cpu_addr(cpu_addr), .cpu_din(cpu_din), .cpu_ds(cpu_ds),
        .cpu_port(cpu_port), .cpu_rd(cpu_rd), .cpu_wr(cpu_wr),
        .bsram_addr(bsram_addr), .bsram_din(bsram_din),
        .bsram_rd(bsram_rd), .bsram_wr(bsram_wr)
    );

    read_data_steer steer0 (
        .mclk(mclk), .resetn(resetn),
        .cpu_port0(cpu_port0), .cpu_port1(cpu_port1),
        .rom_addr(rom_addr), .rom_word(rom_word), .wram_addr(wram_addr),
        .aram_addr(aram_addr), .aram_ce_n(aram_ce_n), .aram_oe_n(aram_oe_n),
        .aram_dout(aram_dout),
        .rom_q(rom_q), .wram_q(wram_q), .aram_q(aram_q)
    );

    vram_read_filter vram_filt0 (
        .mclk(mclk), .resetn(resetn),
        .vram1_addr(vram1_addr), .vram2_addr(vram2_addr), .vram_oe_n(vram_oe_n),
        .vram1_rd(vram1_rd), .vram2_rd(vram2_rd)
    );

endmodule

`default_nettype wire

//--- verification/snes_mem_properties.sv
// bound checks on the SDRAM request stream and the VRAM read serializer
`timescale 1ns/1ns
`default_nettype none

module snes_mem_properties (
    input logic                      mclk,
    input logic                      resetn,
    input snes_mem_pkg::req_kind_t   last_kind,
    input logic                      load_byte,
    input snes_mem_pkg::sdram_addr_t cpu_addr,
    input snes_mem_pkg::word_t       cpu_din,
    input snes_mem_pkg::byte_en_t    cpu_ds,
    input logic                      cpu_port,
    input logic                      cpu_rd,
    input logic                      cpu_wr,
    input logic                      vram2_defer,
    input logic                      vram1_rd,
    input logic                      vram2_rd
);
    import snes_mem_pkg::*;

    int   fail_count;                // failed assertions so far
    logic load_start;

    // loader byte that is taken, not one that lands on a hold cycle
    assign load_start = load_byte & (last_kind != REQ_LOAD);

    load_first: assert property (@(posedge mclk) disable iff (!resetn)
        load_start |=> (cpu_wr && !cpu_port))
        else begin
            fail_count++;
            $error("loader byte gave no write strobe on port 0");
        end

    // second cycle repeats the same write
    load_second: assert property (@(posedge mclk) disable iff (!resetn)
        $past(load_start, 2) |-> (cpu_wr && cpu_addr == $past(cpu_addr) &&
                                  cpu_din == $past(cpu_din) && cpu_ds == $past(cpu_ds)))
        else begin
            fail_count++;
            $error("loader write not held for a second cycle");
        end

    load_ends: assert property (@(posedge mclk) disable iff (!resetn)
        $past(load_start, 3) |-> !(cpu_wr && !cpu_port && last_kind != REQ_LOAD))
        else begin
            fail_count++;
            $error("loader write longer than two cycles");
        end

    rd_wr_apart: assert property (@(posedge mclk) disable iff (!resetn)
        !(cpu_rd && cpu_wr))
        else begin
            fail_count++;
            $error("sdram read and write strobes together");
        end

    // first cycle of a conflict serves port 1 only
    vram_held: assert property (@(posedge mclk) disable iff (!resetn)
        (vram2_defer && !$past(vram2_defer)) |-> (vram1_rd && !vram2_rd))
        else begin
            fail_count++;
            $error("conflicting vram port 2 read was not held back");
        end

    // port 2 read pushed back by a conflict shows up next cycle
    vram_deferred: assert property (@(posedge mclk) disable iff (!resetn)
        vram2_defer |=> vram2_rd)
        else begin
            fail_count++;
            $error("deferred vram port 2 read was lost");
        end

endmodule

`default_nettype wire

//--- verification/snes_mem_tb.sv
// testbench for the SNES memory front end: random bus traffic against a cycle model
`timescale 1ns/1ns
`default_nettype none

`include "snes_mem_cfg.svh"

module snes_mem_tb;
    import snes_mem_pkg::*;

    localparam int MODE_IDLE = 0;
    localparam int MODE_LOAD = 1;
    localparam int MODE_RUN  = 2;

    // dut ports, connected by name
    logic        mclk, resetn, frame_pause, sdram_busy, loading;
    byte_t       loader_do, rom_type, wram_d, bsram_d;
    logic        loader_do_valid, header_finished, sysclkf_ce, sysclkr_ce;
    rom_addr_t   rom_addr;
    logic        rom_ce_n, rom_word, wram_ce_n, wram_rd_n, wram_we_n;
    wram_addr_t  wram_addr;
    bsram_addr_t bsram_addr_cpu, bsram_addr;
    logic        bsram_ce_n, bsram_rd_n, bsram_we_n;
    aram_addr_t  aram_addr;
    logic        aram_ce_n, aram_oe_n, vram_oe_n;
    word_t       aram_dout, cpu_port0, cpu_port1, cpu_din, rom_q;
    vram_addr_t  vram1_addr, vram2_addr;
    logic        enable, cpu_port, cpu_rd, cpu_wr, bsram_rd, bsram_wr;
    sdram_addr_t cpu_addr;
    byte_en_t    cpu_ds;
    byte_t       bsram_din, wram_q, aram_q;
    logic        vram1_rd, vram2_rd;

    // reference model state
    logic                m_loading_r, m_enable, m_f2, m_r2;
    load_state_t         m_state;
    rom_addr_t           m_laddr;
    req_kind_t           m_kind;
    logic                m_rd, m_wr, m_brd, m_bwr, m_port;
    sdram_addr_t         m_addr;
    word_t               m_din;
    byte_en_t            m_ds;
    bsram_addr_t         m_baddr;
    byte_t               m_bdin;
    logic                m_aram_lsb, m_oe_old, m_defer;
    logic [`VRAM_AW-1:0] m_a1_old, m_a2_old;

    logic [63:0] rng;
    int          mode, load_cycles, cycle_count;
    int          n_loads, n_wram_rd, n_wram_wr, n_roms, n_rom_blocked, n_map_blocked;
    int          n_vram_defer;

    snes_mem_top dut0 (.*);

    bind mem_req_arbiter snes_mem_properties arb_props (
        .mclk(mclk), .resetn(resetn), .last_kind(last_kind), .load_byte(load_byte),
        .cpu_addr(cpu_addr), .cpu_din(cpu_din), .cpu_ds(cpu_ds), .cpu_port(cpu_port),
        .cpu_rd(cpu_rd), .cpu_wr(cpu_wr),
        .vram2_defer(1'b0), .vram1_rd(1'b0), .vram2_rd(1'b0)
    );
    bind vram_read_filter snes_mem_properties vram_props (
        .mclk(mclk), .resetn(resetn), .last_kind(snes_mem_pkg::REQ_NONE),
        .load_byte(1'b0), .cpu_addr('0), .cpu_din('0), .cpu_ds('0), .cpu_port(1'b0),
        .cpu_rd(1'b0), .cpu_wr(1'b0),
        .vram2_defer(vram2_delay), .vram1_rd(vram1_rd), .vram2_rd(vram2_rd)
    );

    initial begin
        mclk = 1'b0;
        forever #4 mclk = ~mclk;     // 8 ns period
    end

    initial begin
        #200000;
        $display("simulation watchdog expired before the test sequence ended");
        abort_run();
    end

    // 64 bit lcg, upper half is the usable part
    function automatic logic [31:0] next_rand();
        rng = rng * 64'd6364136223846793005 + 64'd1442695040888963407;
        return rng[63:32];
    endfunction

    function automatic logic vram_fresh(input logic oe_n, input logic oe_old,
                                        input vram_addr_t a,
                                        input logic [`VRAM_AW-1:0] a_old);
        return !oe_n && (oe_old || a[`VRAM_AW-1:0] != a_old);
    endfunction

    task automatic abort_run();
        $display("Regression failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic expect_eq(input string name, input logic [31:0] got,
                             input logic [31:0] want);
        assert (got === want) else begin
            $display("ERROR %s got %h expected %h at %0t ns", name, got, want, $time);
            abort_run();
        end
    endtask

    task automatic expect_seen(input string what, input int count);
        assert (count > 0) else begin
            $display("stimulus never produced %s", what);
            abort_run();
        end
    endtask

    task automatic set_idle();
        loading         = 1'b0;
        loader_do_valid = 1'b0;
        header_finished = 1'b1;
        loader_do       = '0;
        sdram_busy      = 1'b0;
        frame_pause     = 1'b0;
        rom_type        = '0;
        sysclkf_ce      = 1'b0;
        sysclkr_ce      = 1'b0;
        rom_addr        = '0;
        rom_ce_n        = 1'b1;
        rom_word        = 1'b0;
        wram_addr       = '0;
        wram_ce_n       = 1'b1;
        wram_rd_n       = 1'b1;
        wram_we_n       = 1'b1;
        wram_d          = '0;
        bsram_addr_cpu  = '0;
        bsram_ce_n      = 1'b1;
        bsram_rd_n      = 1'b1;
        bsram_we_n      = 1'b1;
        bsram_d         = '0;
        aram_addr       = '0;
        aram_ce_n       = 1'b1;
        aram_oe_n       = 1'b1;
        aram_dout       = '0;
        vram1_addr      = '0;
        vram2_addr      = '0;
        vram_oe_n       = 1'b1;
        cpu_port0       = '0;
        cpu_port1       = '0;
    endtask

    task automatic drive_inputs();
        logic [31:0] r;
        resetn = (cycle_count >= 4);
        if (mode == MODE_IDLE) begin
            set_idle();
        end else begin
            if (mode == MODE_LOAD)
                load_cycles++;
            r = next_rand();
            loading         = (mode == MODE_LOAD);
            loader_do_valid = (mode == MODE_LOAD) && (r[1:0] == 2'b00);
            header_finished = (mode != MODE_LOAD) || (load_cycles > 6);
            loader_do       = r[15:8];
            sdram_busy      = (r[20:18] == 3'd0);
            frame_pause     = (r[23:21] == 3'd0);
            sysclkf_ce      = (r[25:24] == 2'd0);    // phases never overlap
            sysclkr_ce      = (r[25:24] == 2'd2);
            rom_type        = r[26] ? {`ROM_TYPE_SRAM_MAP, r[30:27]} : r[31:24];
            r = next_rand();
            wram_addr = r[16:0];
            wram_ce_n = (r[19:17] > 3'd1);
            wram_rd_n = r[20];
            wram_we_n = !r[20];
            wram_d    = r[28:21];
            r = next_rand();
            rom_addr   = r[23:0];
            rom_ce_n   = r[24];
            rom_word   = r[25];
            bsram_ce_n = (r[27:26] != 2'd0);
            bsram_rd_n = r[28];
            bsram_we_n = r[29];
            r = next_rand();
            bsram_addr_cpu = r[19:0];
            bsram_d        = r[27:20];
            r = next_rand();
            cpu_port0 = r[15:0];
            cpu_port1 = r[31:16];
            r = next_rand();
            aram_addr = r[15:0];
            aram_dout = r[31:16];
            r = next_rand();
            aram_ce_n = r[0];
            aram_oe_n = r[1];
            vram_oe_n = (r[3:2] == 2'd0);
            if (!r[4]) begin                      // small pool, lots of repeats
                vram1_addr = {r[5], 12'h000, r[8:6]};
                vram2_addr = {r[9], 12'h000, r[12:10]};
            end
        end
    endtask

    // one clock edge of the reference model, from the inputs before the edge
    task automatic advance_model();
        logic      load_byte, wram_go, brd_term, rd, wr, new1, new2;
        req_kind_t kind;
        cycle_count++;
        if (!resetn) begin
            m_loading_r = 1'b0;
            m_state     = LOAD_IDLE;
            m_laddr     = '0;
            m_enable    = 1'b0;
            m_f2        = 1'b0;
            m_r2        = 1'b0;
            m_kind      = REQ_NONE;
            m_rd        = 1'b0;
            m_wr        = 1'b0;
            m_brd       = 1'b0;
            m_bwr       = 1'b0;
            m_aram_lsb  = 1'b0;
            m_oe_old    = 1'b1;
            m_defer     = 1'b0;
        end else begin
            load_byte = loading && loader_do_valid && header_finished;
            wram_go   = !wram_ce_n && (!wram_rd_n || !wram_we_n);
            brd_term  = !bsram_ce_n && m_f2 &&
                        (!bsram_rd_n || rom_type[7:4] == `ROM_TYPE_SRAM_MAP);
            kind = REQ_NONE;
            rd   = 1'b0;
            wr   = 1'b0;
            if (m_kind == REQ_LOAD) begin
                kind = REQ_LOAD_HOLD;
                wr   = 1'b1;
            end else if (load_byte) begin
                kind   = REQ_LOAD;
                wr     = 1'b1;
                m_addr = m_laddr[`SDRAM_AW-1:0];
                m_din  = {loader_do, loader_do};
                m_ds   = m_laddr[0] ? 2'b10 : 2'b01;
                m_port = 1'b0;
                n_loads++;
            end else if (wram_go) begin
                kind   = REQ_WRAM;
                m_addr = {`WRAM_BANK_PREFIX, wram_addr};
                m_ds   = wram_addr[0] ? 2'b10 : 2'b01;
                m_port = 1'b1;
                rd     = !wram_rd_n && m_f2;
                wr     = !wram_we_n && m_r2;
                n_wram_rd += int'(rd);
                n_wram_wr += int'(wr);
            end else if (!rom_ce_n && m_f2) begin
                if (brd_term) begin
                    n_rom_blocked++;
                    n_map_blocked += int'(bsram_rd_n);   // blocked by rom_type only
                end else begin
                    kind   = REQ_ROM;
                    rd     = 1'b1;
                    m_addr = rom_addr[`SDRAM_AW-1:0];
                    m_ds   = 2'b11;
                    m_port = 1'b0;
                    n_roms++;
                end
            end
            m_kind = kind;
            m_rd   = rd;
            m_wr   = wr;
            m_brd  = brd_term;
            m_bwr  = !bsram_ce_n && !bsram_we_n && m_r2;
            m_f2   = sysclkf_ce && m_enable;
            m_r2   = sysclkr_ce && m_enable;
            m_enable = !sdram_busy && !frame_pause && (m_state == LOAD_DONE);
            if (loading && !m_loading_r) begin
                m_laddr = '0;
                m_state = LOAD_ACTIVE;
            end else begin
                if (loader_do_valid && header_finished)
                    m_laddr = m_laddr + 24'd1;
                if (!loading && m_loading_r)
                    m_state = LOAD_DONE;
            end
            m_loading_r = loading;
            if (!aram_ce_n && !aram_oe_n)
                m_aram_lsb = aram_addr[0];
            new1 = vram_fresh(vram_oe_n, m_oe_old, vram1_addr, m_a1_old);
            new2 = vram_fresh(vram_oe_n, m_oe_old, vram2_addr, m_a2_old);
            m_defer = new1 && new2 && (vram1_addr != vram2_addr);
            n_vram_defer += int'(m_defer);
            m_oe_old = vram_oe_n;
        end
        m_baddr  = bsram_addr_cpu;
        m_bdin   = bsram_d;
        m_a1_old = vram1_addr[`VRAM_AW-1:0];
        m_a2_old = vram2_addr[`VRAM_AW-1:0];
    endtask

    task automatic compare_outputs();
        word_t exp_rom;
        byte_t exp_wram, exp_aram;
        logic  new1, new2, exp_v2;
        assert (dut0.arb0.arb_props.fail_count == 0 &&
                dut0.vram_filt0.vram_props.fail_count == 0) else begin
            $display("a bound property on the arbiter or the VRAM filter failed");
            abort_run();
        end
        expect_eq("enable", 32'(enable), 32'(m_enable));
        expect_eq("cpu_rd", 32'(cpu_rd), 32'(m_rd));
        expect_eq("cpu_wr", 32'(cpu_wr), 32'(m_wr));
        expect_eq("bsram_rd", 32'(bsram_rd), 32'(m_brd));
        expect_eq("bsram_wr", 32'(bsram_wr), 32'(m_bwr));
        expect_eq("bsram_addr", 32'(bsram_addr), 32'(m_baddr));
        expect_eq("bsram_din", 32'(bsram_din), 32'(m_bdin));
        if (m_kind != REQ_NONE) begin                 // payload only defined once served
            expect_eq("cpu_addr", 32'(cpu_addr), 32'(m_addr));
            expect_eq("cpu_ds", 32'(cpu_ds), 32'(m_ds));
            expect_eq("cpu_port", 32'(cpu_port), 32'(m_port));
        end
        if (m_kind == REQ_LOAD || m_kind == REQ_LOAD_HOLD)
            expect_eq("cpu_din", 32'(cpu_din), 32'(m_din));
        // odd byte fetch gets the high byte in the low lane
        exp_rom = (rom_addr[0] && !rom_word) ? {cpu_port0[7:0], cpu_port0[15:8]} : cpu_port0;
        expect_eq("rom_q", 32'(rom_q), 32'(exp_rom));
        exp_wram = byte_t'(cpu_port1 >> {wram_addr[0], 3'b000});   // addressed byte to lane 0
        exp_aram = byte_t'(aram_dout >> {m_aram_lsb, 3'b000});
        expect_eq("wram_q", 32'(wram_q), 32'(exp_wram));
        expect_eq("aram_q", 32'(aram_q), 32'(exp_aram));
        new1 = vram_fresh(vram_oe_n, m_oe_old, vram1_addr, m_a1_old);
        new2 = vram_fresh(vram_oe_n, m_oe_old, vram2_addr, m_a2_old);
        exp_v2 = (new2 && !(new1 && vram1_addr != vram2_addr)) || m_defer;
        expect_eq("vram1_rd", 32'(vram1_rd), 32'(new1));
        expect_eq("vram2_rd", 32'(vram2_rd), 32'(exp_v2));
    endtask

    task automatic run_cycle();
        @(posedge mclk);
        advance_model();
        #1;
        drive_inputs();
        #3;                                           // sample mid cycle
        compare_outputs();
    endtask

    task automatic wait_for_enable();
        int n;
        n = 0;
        run_cycle();
        while (!enable) begin
            n++;
            if (n > 64) begin
                $display("enable did not rise after loading ended");
                abort_run();
            end
            run_cycle();
        end
    endtask

    task automatic drain_outputs();
        int n;
        n = 0;
        run_cycle();
        while (cpu_rd || cpu_wr || bsram_rd || bsram_wr || vram2_rd) begin
            n++;
            if (n > 16) begin
                $display("request strobes did not return to idle");
                abort_run();
            end
            run_cycle();
        end
    endtask

    initial begin
        rng         = 64'd30;
        resetn      = 1'b0;
        mode        = MODE_IDLE;
        load_cycles = 0;
        cycle_count = 0;
        set_idle();
        repeat (6) run_cycle();                       // 4 in reset, then idle
        mode = MODE_LOAD;
        repeat (300) run_cycle();
        mode = MODE_RUN;
        wait_for_enable();
        repeat (3000) run_cycle();
        mode        = MODE_LOAD;                      // reload while the console runs
        load_cycles = 0;
        repeat (150) run_cycle();
        mode = MODE_RUN;
        wait_for_enable();
        repeat (400) run_cycle();
        mode = MODE_IDLE;
        drain_outputs();
        expect_seen("a loader write", n_loads);
        expect_seen("a WRAM read", n_wram_rd);
        expect_seen("a WRAM write", n_wram_wr);
        expect_seen("a ROM read", n_roms);
        expect_seen("a ROM read blocked by BSRAM", n_rom_blocked);
        expect_seen("a ROM read blocked by the SRAM mapped rom_type", n_map_blocked);
        expect_seen("a deferred VRAM port 2 read", n_vram_defer);
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+source
source/snes_mem_pkg.sv
source/load_ctrl.sv
source/mem_req_arbiter.sv
source/read_data_steer.sv
source/vram_read_filter.sv
source/snes_mem_top.sv
verification/snes_mem_properties.sv
verification/snes_mem_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= snes_mem_tb
LINT_TOP  ?= snes_mem_top
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Regression passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
